/* Makefile */
# Verilator build and run of the shared multi-FIFO testbench
TOP := shared_mfifo_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf obj_dir $(LOG)

/* hdl/entry_freelist.sv */
// Free-entry bitmap, offers the lowest free index each cycle.
// A take and a dealloc on the same edge never name the same entry.
`default_nettype none

module entry_freelist (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          alloc_take,
  input  wire                          dealloc_valid,
  input  mfifo_flow_pkg::dealloc_t     dealloc,
  output logic                         alloc_valid,
  output mfifo_cfg_pkg::entry_id_t     alloc_entry
);

  // One bit per entry, set means free
  logic [mfifo_cfg_pkg::Depth-1:0] free_q;
  logic [mfifo_cfg_pkg::Depth-1:0] free_d;

  assign alloc_valid = |free_q;

  // Priority pick, lowest index wins
  always_comb begin
    alloc_entry = '0;
    for (int i = mfifo_cfg_pkg::Depth - 1; i >= 0; i--) begin
      if (free_q[i]) begin
        alloc_entry = mfifo_cfg_pkg::entry_id_t'(i);
      end
    end
  end

  always_comb begin
    free_d = free_q;
    if (alloc_take) begin
      free_d[alloc_entry] = 1'b0;
    end
    // Returned entry is free again next cycle
    if (dealloc_valid) begin
      free_d[dealloc.entry] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      free_q <= '1;
    end else begin
      free_q <= free_d;
    end
  end

endmodule

`default_nettype wire

/* hdl/fifo_link_ctrl.sv */
// Linked-list state for every logical FIFO plus the shared next-pointer table.
// A pop on an empty FIFO is never issued by the pop side.
`default_nettype none

module fifo_link_ctrl (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          tail_valid,
  input  mfifo_flow_pkg::tail_upd_t    tail_upd,
  input  wire                          head_pop,
  input  mfifo_cfg_pkg::fifo_id_t      head_pop_id,
  output logic [mfifo_cfg_pkg::NumFifos-1:0] fifo_nonempty,
  output mfifo_cfg_pkg::entry_id_t [mfifo_cfg_pkg::NumFifos-1:0] head_entry
);

  mfifo_cfg_pkg::entry_id_t head_q  [mfifo_cfg_pkg::NumFifos];
  mfifo_cfg_pkg::entry_id_t head_d  [mfifo_cfg_pkg::NumFifos];
  mfifo_cfg_pkg::entry_id_t tail_q  [mfifo_cfg_pkg::NumFifos];
  mfifo_cfg_pkg::entry_id_t tail_d  [mfifo_cfg_pkg::NumFifos];
  mfifo_cfg_pkg::count_t    count_q [mfifo_cfg_pkg::NumFifos];
  mfifo_cfg_pkg::count_t    count_d [mfifo_cfg_pkg::NumFifos];

  // Successor of each entry within its FIFO
  mfifo_cfg_pkg::entry_id_t next_q [mfifo_cfg_pkg::Depth];

  mfifo_cfg_pkg::fifo_id_t  push_id;
  logic                     link_wr;
  mfifo_cfg_pkg::entry_id_t link_addr;

  assign push_id   = tail_upd.fifo_id;
  assign link_addr = tail_q[push_id];

  always_comb begin
    for (int f = 0; f < mfifo_cfg_pkg::NumFifos; f++) begin
      fifo_nonempty[f] = (count_q[f] != '0);
      head_entry[f]    = head_q[f];
    end
  end

  // Pop first, so a push sees the count left after a same-cycle pop
  always_comb begin
    head_d  = head_q;
    tail_d  = tail_q;
    count_d = count_q;
    link_wr = 1'b0;
    if (head_pop) begin
      // Last word leaves the head pointer stale, which is harmless
      if (count_q[head_pop_id] > mfifo_cfg_pkg::count_t'(1)) begin
        head_d[head_pop_id] = next_q[head_q[head_pop_id]];
      end
      count_d[head_pop_id] = count_d[head_pop_id] - 1'b1;
    end
    if (tail_valid) begin
      if (count_d[push_id] == '0) begin
        head_d[push_id] = tail_upd.entry;
      end else begin
        link_wr = 1'b1;
      end
      tail_d[push_id]  = tail_upd.entry;
      count_d[push_id] = count_d[push_id] + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int f = 0; f < mfifo_cfg_pkg::NumFifos; f++) begin
        head_q[f]  <= '0;
        tail_q[f]  <= '0;
        count_q[f] <= '0;
      end
    end else begin
      head_q  <= head_d;
      tail_q  <= tail_d;
      count_q <= count_d;
    end
  end

  // Link old tail to the new entry
  always_ff @(posedge clk) begin
    if (link_wr) begin
      next_q[link_addr] <= tail_upd.entry;
    end
  end

endmodule

`default_nettype wire

/* hdl/mfifo_cfg_pkg.sv */
// Sizes of the shared multi-FIFO and the vector types built on them.
// Changing a size here resizes every block and the packed structs with it.
`default_nettype none

package mfifo_cfg_pkg;

  // Number of logical FIFOs sharing the storage
  localparam int NumFifos = 4;
  // Number of shared RAM entries
  localparam int Depth = 16;
  // Data word width in bits
  localparam int Width = 16;

  // Logical FIFO index
  typedef logic [$clog2(NumFifos)-1:0] fifo_id_t;
  // Shared RAM entry index
  typedef logic [$clog2(Depth)-1:0] entry_id_t;
  // One data word
  typedef logic [Width-1:0] data_t;
  // Per-FIFO occupancy, 0 to Depth inclusive
  typedef logic [$clog2(Depth+1)-1:0] count_t;

endpackage

`default_nettype wire

/* hdl/mfifo_flow_pkg.sv */
// Bundles passed between the multi-FIFO blocks.
// Valid strobes travel beside these structs, not inside them.
`default_nettype none

package mfifo_flow_pkg;

  // Incoming push, target FIFO plus payload
  typedef struct packed {
    mfifo_cfg_pkg::fifo_id_t fifo_id;
    mfifo_cfg_pkg::data_t    data;
  } push_item_t;

  // RAM write request
  typedef struct packed {
    mfifo_cfg_pkg::entry_id_t entry;
    mfifo_cfg_pkg::data_t     data;
  } ram_wr_t;

  // New tail entry for one FIFO
  typedef struct packed {
    mfifo_cfg_pkg::fifo_id_t  fifo_id;
    mfifo_cfg_pkg::entry_id_t entry;
  } tail_upd_t;

  // Entry handed back to the freelist after a pop
  typedef struct packed {
    mfifo_cfg_pkg::entry_id_t entry;
  } dealloc_t;

endpackage

`default_nettype wire

/* hdl/shared_data_ram.sv */
// Shared data storage, Depth words of flops.
// Written on the clock edge, read combinationally, contents undefined after reset.
`default_nettype none

module shared_data_ram (
  input  wire                          clk,
  input  wire                          ram_wr_valid,
  input  mfifo_flow_pkg::ram_wr_t      ram_wr,
  input  mfifo_cfg_pkg::entry_id_t     rd_entry,
  output mfifo_cfg_pkg::data_t         rd_data
);

  mfifo_cfg_pkg::data_t mem [mfifo_cfg_pkg::Depth];

  always_ff @(posedge clk) begin
    if (ram_wr_valid) begin
      mem[ram_wr.entry] <= ram_wr.data;
    end
  end

  // Read of the selected head, no latency
  assign rd_data = mem[rd_entry];

endmodule

`default_nettype wire

/* hdl/shared_mfifo.sv */
// Multi-FIFO with one shared RAM and per-FIFO linked lists.
// One push port and one pop port, both valid/ready, pop data has zero latency.
`default_nettype none

module shared_mfifo (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          push_valid,
  input  mfifo_flow_pkg::push_item_t   push_item,
  input  mfifo_cfg_pkg::fifo_id_t      pop_fifo_id,
  input  wire                          pop_ready,
  output logic                         push_ready,
  output logic                         push_full,
  output logic                         pop_valid,
  output mfifo_cfg_pkg::data_t         pop_data
);

  logic                                 alloc_valid;
  mfifo_cfg_pkg::entry_id_t             alloc_entry;
  logic                                 alloc_take;
  logic                                 ram_wr_valid;
  mfifo_flow_pkg::ram_wr_t              ram_wr;
  logic                                 tail_valid;
  mfifo_flow_pkg::tail_upd_t            tail_upd;
  logic [mfifo_cfg_pkg::NumFifos-1:0]   fifo_nonempty;
  mfifo_cfg_pkg::entry_id_t [mfifo_cfg_pkg::NumFifos-1:0] head_entry;
  mfifo_cfg_pkg::entry_id_t             rd_entry;
  mfifo_cfg_pkg::data_t                 rd_data;
  logic                                 head_pop;
  mfifo_cfg_pkg::fifo_id_t              head_pop_id;
  logic                                 dealloc_valid;
  mfifo_flow_pkg::dealloc_t             dealloc;

  entry_freelist u_freelist (
    .clk, .rst, .alloc_take, .dealloc_valid, .dealloc, .alloc_valid, .alloc_entry
  );

  shared_push_ctrl u_push_ctrl (
    .push_valid, .push_item, .alloc_valid, .alloc_entry, .push_ready, .push_full,
    .alloc_take, .ram_wr_valid, .tail_valid, .ram_wr, .tail_upd
  );

  fifo_link_ctrl u_link_ctrl (
    .clk, .rst, .tail_valid, .tail_upd, .head_pop, .head_pop_id, .fifo_nonempty, .head_entry
  );

  shared_data_ram u_data_ram (
    .clk, .ram_wr_valid, .ram_wr, .rd_entry, .rd_data
  );

  shared_pop_ctrl u_pop_ctrl (
    .pop_fifo_id, .pop_ready, .fifo_nonempty, .head_entry, .rd_data, .pop_valid, .pop_data,
    .rd_entry, .head_pop, .head_pop_id, .dealloc_valid, .dealloc
  );

endmodule

`default_nettype wire

/* hdl/shared_pop_ctrl.sv */
// Pop side of the shared multi-FIFO, fully combinational.
// Data follows pop_fifo_id in the same cycle.
`default_nettype none

module shared_pop_ctrl (
  input  mfifo_cfg_pkg::fifo_id_t      pop_fifo_id,
  input  wire                          pop_ready,
  input  wire [mfifo_cfg_pkg::NumFifos-1:0] fifo_nonempty,
  input  mfifo_cfg_pkg::entry_id_t [mfifo_cfg_pkg::NumFifos-1:0] head_entry,
  input  mfifo_cfg_pkg::data_t         rd_data,
  output logic                         pop_valid,
  output mfifo_cfg_pkg::data_t         pop_data,
  output mfifo_cfg_pkg::entry_id_t     rd_entry,
  output logic                         head_pop,
  output mfifo_cfg_pkg::fifo_id_t      head_pop_id,
  output logic                         dealloc_valid,
  output mfifo_flow_pkg::dealloc_t     dealloc
);

  logic pop_xfer;

  // Select the addressed FIFO
  assign pop_valid = fifo_nonempty[pop_fifo_id];
  assign rd_entry  = head_entry[pop_fifo_id];
  assign pop_data  = rd_data;

  assign pop_xfer = pop_valid & pop_ready;

  // Advance that FIFO's head
  assign head_pop    = pop_xfer;
  assign head_pop_id = pop_fifo_id;

  // Popped entry goes back to the freelist
  assign dealloc_valid = pop_xfer;
  assign dealloc.entry = rd_entry;

endmodule

`default_nettype wire

/* hdl/shared_push_ctrl.sv */
// Push side of the shared multi-FIFO, fully combinational.
// Ready depends only on the freelist, never on push_valid.
`default_nettype none

module shared_push_ctrl (
  input  wire                          push_valid,
  input  mfifo_flow_pkg::push_item_t   push_item,
  input  wire                          alloc_valid,
  input  mfifo_cfg_pkg::entry_id_t     alloc_entry,
  output logic                         push_ready,
  output logic                         push_full,
  output logic                         alloc_take,
  output logic                         ram_wr_valid,
  output logic                         tail_valid,
  output mfifo_flow_pkg::ram_wr_t      ram_wr,
  output mfifo_flow_pkg::tail_upd_t    tail_upd
);

  logic push_xfer;

  // Any free entry means a push can land
  assign push_ready = alloc_valid;
  assign push_full  = ~alloc_valid;
  assign push_xfer  = push_valid & push_ready;

  // Claim the offered entry on a transfer
  assign alloc_take = push_xfer;

  // Data goes straight into the claimed entry
  assign ram_wr_valid = push_xfer;
  assign ram_wr.entry = alloc_entry;
  assign ram_wr.data  = push_item.data;

  // Same entry becomes the new tail of the addressed FIFO
  assign tail_valid       = push_xfer;
  assign tail_upd.fifo_id = push_item.fifo_id;
  assign tail_upd.entry   = alloc_entry;

endmodule

`default_nettype wire

/* sim.f */
hdl/mfifo_cfg_pkg.sv
hdl/mfifo_flow_pkg.sv
hdl/entry_freelist.sv
hdl/shared_push_ctrl.sv
hdl/fifo_link_ctrl.sv
hdl/shared_data_ram.sv
hdl/shared_pop_ctrl.sv
hdl/shared_mfifo.sv
test/shared_mfifo_assert.sv
test/shared_mfifo_tb.sv

/* test/shared_mfifo_assert.sv */
// Concurrent checks bound into shared_mfifo.
// Needs assertion support enabled in the simulator.
`default_nettype none

module shared_mfifo_assert (
  input wire                  clk,
  input wire                  rst,
  input wire                  push_ready,
  input wire                  push_full,
  input wire                  pop_valid,
  input mfifo_cfg_pkg::data_t pop_data
);
  timeunit 1ns;
  timeprecision 100ps;

  // Full flag is the inverse of ready
  full_is_not_ready: assert property (
    @(posedge clk) disable iff (rst) push_full == !push_ready
  ) else $error("push_full is not the inverse of push_ready");

  // All FIFOs empty once reset is released
  empty_after_reset: assert property (
    @(posedge clk) rst |=> !pop_valid
  ) else $error("pop_valid is high in the cycle after reset");

  // Head word always defined when offered
  data_known: assert property (
    @(posedge clk) disable iff (rst) pop_valid |-> !$isunknown(pop_data)
  ) else $error("pop_data has unknown bits while pop_valid is high");

endmodule

`default_nettype wire

/* test/shared_mfifo_tb.sv */
// Random push/pop traffic checked against one queue per FIFO.
// Outputs are sampled on the falling edge, inputs change on the rising edge.
`default_nettype none

module shared_mfifo_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RandomCycles  = 2850;
  localparam int TestCycles    = RandomCycles + 8 * mfifo_cfg_pkg::Depth + 24;
  localparam int TimeoutCycles = TestCycles * 5 / 3;

  logic clk;
  logic rst;
  logic push_valid;
  mfifo_flow_pkg::push_item_t push_item;
  mfifo_cfg_pkg::fifo_id_t pop_fifo_id;
  logic pop_ready;
  logic push_ready;
  logic push_full;
  logic pop_valid;
  mfifo_cfg_pkg::data_t pop_data;

  // Reference model
  mfifo_cfg_pkg::data_t model_q [mfifo_cfg_pkg::NumFifos][$];
  int occupancy;
  int seed;
  logic [31:0] rnd;
  logic [31:0] rnd_data;
  logic [3:0] push_duty;
  logic [3:0] pop_duty;
  int cycle_count;
  int check_count;
  int mismatch_count;

  shared_mfifo UUT (
    .clk, .rst, .push_valid, .push_item, .pop_fifo_id, .pop_ready,
    .push_ready, .push_full, .pop_valid, .pop_data
  );

  bind shared_mfifo shared_mfifo_assert u_assert (
    .clk, .rst, .push_ready, .push_full, .pop_valid, .pop_data
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TimeoutCycles) begin
      $display("Timeout: test did not finish within %0d cycles", TimeoutCycles);
      $display("Simulation failed");
      $finish;
    end
  end

  // Compare outputs with the model, then apply the handshakes it predicts
  task automatic check_and_update();
    logic exp_ready;
    logic exp_valid;
    mfifo_cfg_pkg::data_t exp_data;
    exp_ready = (occupancy < mfifo_cfg_pkg::Depth);
    exp_valid = (model_q[pop_fifo_id].size() != 0);
    exp_data  = exp_valid ? model_q[pop_fifo_id][0] : '0;
    check_count++;
    assert (push_ready === exp_ready) else begin
      mismatch_count++;
      $display("Mismatch at %0t: push_ready expected %0b got %0b", $time, exp_ready, push_ready);
    end
    assert (push_full === !exp_ready) else begin
      mismatch_count++;
      $display("Mismatch at %0t: push_full expected %0b got %0b", $time, !exp_ready, push_full);
    end
    assert (pop_valid === exp_valid) else begin
      mismatch_count++;
      $display("Mismatch at %0t: pop_valid expected %0b got %0b", $time, exp_valid, pop_valid);
    end
    assert (!exp_valid || pop_data === exp_data) else begin
      mismatch_count++;
      $display("Mismatch at %0t: pop_data expected %h got %h", $time, exp_data, pop_data);
    end
    if (pop_ready && exp_valid) begin
      void'(model_q[pop_fifo_id].pop_front());
      occupancy--;
    end
    if (push_valid && exp_ready) begin
      model_q[push_item.fifo_id].push_back(push_item.data);
      occupancy++;
    end
  endtask

  task automatic step(input logic pv, input mfifo_cfg_pkg::fifo_id_t fid,
                      input mfifo_cfg_pkg::data_t data, input mfifo_cfg_pkg::fifo_id_t pid,
                      input logic pr);
    @(posedge clk);
    push_valid        <= pv;
    push_item.fifo_id <= fid;
    push_item.data    <= data;
    pop_fifo_id       <= pid;
    pop_ready         <= pr;
    @(negedge clk);
    check_and_update();
  endtask

  // Pop from the lowest non-empty FIFO until all are empty
  task automatic drain_all();
    mfifo_cfg_pkg::fifo_id_t pid;
    while (occupancy > 0) begin
      pid = '0;
      for (int f = mfifo_cfg_pkg::NumFifos - 1; f >= 0; f--) begin
        if (model_q[f].size() != 0) pid = mfifo_cfg_pkg::fifo_id_t'(f);
      end
      step(1'b0, '0, '0, pid, 1'b1);
    end
  endtask

  task automatic fill_all(input mfifo_cfg_pkg::data_t base);
    int k;
    k = 0;
    while (occupancy < mfifo_cfg_pkg::Depth) begin
      rnd = $random(seed);
      step(1'b1, rnd[1:0], base + mfifo_cfg_pkg::data_t'(k), '0, 1'b0);
      k++;
    end
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    push_valid = 1'b0;
    push_item = '0;
    pop_fifo_id = '0;
    pop_ready = 1'b0;
    seed = 32'h48e8;
    occupancy = 0;
    cycle_count = 0;
    check_count = 0;
    mismatch_count = 0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // Reset state seen from every pop id
    for (int f = 0; f < mfifo_cfg_pkg::NumFifos; f++) begin
      step(1'b0, '0, '0, mfifo_cfg_pkg::fifo_id_t'(f), 1'b0);
    end

    // Random traffic, push heavy first and pop heavy later
    for (int n = 0; n < RandomCycles; n++) begin
      rnd = $random(seed);
      rnd_data = $random(seed);
      push_duty = (n < RandomCycles / 2) ? 4'd11 : 4'd6;
      pop_duty  = (n < RandomCycles / 2) ? 4'd6 : 4'd11;
      step(rnd[3:0] < push_duty, rnd[11:10], rnd_data[15:0], rnd[9:8], rnd[7:4] < pop_duty);
    end

    // Full, then a refused push
    drain_all();
    fill_all(16'h1000);
    step(1'b1, 2'd1, 16'hdead, '0, 1'b0);

    // Entries come back after a full drain
    drain_all();
    fill_all(16'h2000);
    drain_all();

    // Push and pop on the same single-word FIFO
    for (int f = 0; f < mfifo_cfg_pkg::NumFifos; f++) begin
      step(1'b1, mfifo_cfg_pkg::fifo_id_t'(f), 16'h3000 + mfifo_cfg_pkg::data_t'(f),
           mfifo_cfg_pkg::fifo_id_t'(f), 1'b0);
      step(1'b1, mfifo_cfg_pkg::fifo_id_t'(f), 16'h3100 + mfifo_cfg_pkg::data_t'(f),
           mfifo_cfg_pkg::fifo_id_t'(f), 1'b1);
      step(1'b0, '0, '0, mfifo_cfg_pkg::fifo_id_t'(f), 1'b1);
    end

    // Every FIFO empty again
    for (int f = 0; f < mfifo_cfg_pkg::NumFifos; f++) begin
      step(1'b0, '0, '0, mfifo_cfg_pkg::fifo_id_t'(f), 1'b0);
    end

    $display("Checks: %0d, mismatches: %0d", check_count, mismatch_count);
    if (mismatch_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
